// File: src/alu_pkg.sv
`default_nettype none

package alu_pkg;

    // datapath width and shift amount
    localparam int XLEN    = 64;
    localparam int SHAMT_W = 6;

    typedef logic [XLEN-1:0] word_t;

    // iteration counts of the long units
    localparam int MUL_STEPS = 64;
    localparam int DIV_STEPS = 64;
    localparam int MUL_CNT_W = $clog2(MUL_STEPS);
    localparam int DIV_CNT_W = $clog2(DIV_STEPS);

    localparam logic [MUL_CNT_W-1:0] MUL_LAST = MUL_CNT_W'(MUL_STEPS - 1);
    localparam logic [DIV_CNT_W-1:0] DIV_LAST = DIV_CNT_W'(DIV_STEPS - 1);

    // single-cycle ops first, then long ops
    typedef enum logic [4:0] {
        OP_ADD    = 5'd0,
        OP_SUB    = 5'd1,
        OP_PASS_A = 5'd2,
        OP_PASS_B = 5'd3,
        OP_XOR    = 5'd4,
        OP_OR     = 5'd5,
        OP_AND    = 5'd6,
        OP_SLL    = 5'd7,
        OP_SRL    = 5'd8,
        OP_SRA    = 5'd9,
        OP_SLT    = 5'd10,
        OP_SLTU   = 5'd11,
        OP_EQ     = 5'd12,
        OP_GE     = 5'd13,
        OP_GEU    = 5'd14,
        OP_MUL    = 5'd15,
        OP_DIV    = 5'd16,
        OP_DIVU   = 5'd17,
        OP_REM    = 5'd18,
        OP_REMU   = 5'd19
    } alu_op_e;

    typedef enum logic [0:0] {
        SEL_A_PC  = 1'b0,
        SEL_A_RS1 = 1'b1
    } sel_a_e;

    typedef enum logic [1:0] {
        SEL_B_IMM = 2'd0,
        SEL_B_RS2 = 2'd1,
        SEL_B_CSR = 2'd2
    } sel_b_e;

    typedef enum logic [1:0] {
        DK_DIV  = 2'd0,
        DK_DIVU = 2'd1,
        DK_REM  = 2'd2,
        DK_REMU = 2'd3
    } div_kind_e;

    // control FSM of the execute block
    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        WAIT_MUL = 2'd1,
        WAIT_DIV = 2'd2
    } exec_state_e;

    // divider sequencing
    typedef enum logic [1:0] {
        DV_IDLE = 2'd0,
        DV_RUN  = 2'd1,
        DV_FIN  = 2'd2
    } div_state_e;

endpackage

`default_nettype wire

// File: src/exec_alu.sv
`timescale 1ns/1ns
`default_nettype none

module exec_alu import alu_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        flush,
    input  logic        in_valid,
    output logic        in_ready,
    input  alu_op_e     op,
    input  sel_a_e      sel_a,
    input  sel_b_e      sel_b,
    input  logic        word_mode,
    input  word_t       pc,
    input  word_t       rs1,
    input  word_t       rs2,
    input  word_t       csr,
    input  word_t       imm,
    output logic        out_valid,
    input  logic        out_ready,
    output word_t       res,
    output logic        mul_start,
    output word_t       mul_a,
    output word_t       mul_b,
    input  logic        mul_done,
    input  word_t       mul_prod,
    output logic        div_start,
    output div_kind_e   div_kind,
    output word_t       div_a,
    output word_t       div_b,
    input  logic        div_done,
    input  word_t       div_res
);

    exec_state_e state;

    word_t               a_op;
    word_t               b_op;
    word_t               alu_res;
    logic [SHAMT_W-1:0]  shamt;
    logic [31:0]         sra_w;
    logic                accept;
    logic                is_mul;
    logic                is_div;
    div_kind_e           kind_nxt;

    // first operand, word mode keeps only the low half of rs1
    always_comb begin
        if (sel_a == SEL_A_RS1) begin
            a_op = word_mode ? {32'b0, rs1[31:0]} : rs1;
        end else begin
            a_op = pc;
        end
    end

    always_comb begin
        case (sel_b)
            SEL_B_RS2: b_op = rs2;
            SEL_B_CSR: b_op = csr;
            default:   b_op = imm;
        endcase
    end

    assign shamt = b_op[SHAMT_W-1:0];
    assign sra_w = $signed(a_op[31:0]) >>> shamt;

    always_comb begin
        case (op)
            OP_ADD:    alu_res = a_op + b_op;
            OP_SUB:    alu_res = a_op - b_op;
            OP_PASS_A: alu_res = a_op;
            OP_PASS_B: alu_res = b_op;
            OP_XOR:    alu_res = a_op ^ b_op;
            OP_OR:     alu_res = a_op | b_op;
            OP_AND:    alu_res = a_op & b_op;
            OP_SLL:    alu_res = a_op << shamt;
            OP_SRL:    alu_res = a_op >> shamt;
            OP_SRA: begin
                // word form is zero-extended, not sign-extended
                if (word_mode) begin
                    alu_res = {32'b0, sra_w};
                end else begin
                    alu_res = $signed(a_op) >>> shamt;
                end
            end
            OP_SLT:    alu_res = word_t'($signed(a_op) < $signed(b_op));
            OP_SLTU:   alu_res = word_t'(a_op < b_op);
            OP_EQ:     alu_res = word_t'(a_op == b_op);
            OP_GE:     alu_res = word_t'($signed(a_op) >= $signed(b_op));
            OP_GEU:    alu_res = word_t'(a_op >= b_op);
            default:   alu_res = '0;
        endcase
    end

    always_comb begin
        case (op)
            OP_DIVU: kind_nxt = DK_DIVU;
            OP_REM:  kind_nxt = DK_REM;
            OP_REMU: kind_nxt = DK_REMU;
            default: kind_nxt = DK_DIV;
        endcase
    end

    assign is_mul = (op == OP_MUL);
    assign is_div = op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};

    // free result slot or one being drained this cycle
    assign in_ready = (state == IDLE) && (!out_valid || out_ready);
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            out_valid <= 1'b0;
            mul_start <= 1'b0;
            div_start <= 1'b0;
        end else if (flush) begin
            state     <= IDLE;
            out_valid <= 1'b0;
            mul_start <= 1'b0;
            div_start <= 1'b0;
        end else begin
            mul_start <= 1'b0;
            div_start <= 1'b0;
            if (out_valid && out_ready) begin
                out_valid <= 1'b0;
            end
            case (state)
                IDLE: begin
                    if (accept) begin
                        if (is_mul) begin
                            mul_start <= 1'b1;
                            state     <= WAIT_MUL;
                        end else if (is_div) begin
                            div_start <= 1'b1;
                            state     <= WAIT_DIV;
                        end else begin
                            out_valid <= 1'b1;
                        end
                    end
                end
                WAIT_MUL: begin
                    if (mul_done) begin
                        out_valid <= 1'b1;
                        state     <= IDLE;
                    end
                end
                WAIT_DIV: begin
                    if (div_done) begin
                        out_valid <= 1'b1;
                        state     <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // result and long-unit operands
    always_ff @(posedge clk) begin
        if (accept && is_mul) begin
            mul_a <= a_op;
            mul_b <= b_op;
        end
        if (accept && is_div) begin
            div_a    <= a_op;
            div_b    <= b_op;
            div_kind <= kind_nxt;
        end
        if (accept && !is_mul && !is_div) begin
            res <= alu_res;
        end else if (state == WAIT_MUL && mul_done) begin
            res <= mul_prod;
        end else if (state == WAIT_DIV && div_done) begin
            res <= div_res;
        end
    end

    // held result must not move under back-pressure
    a_res_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> $stable(res));

    // only one long unit started at a time
    a_one_start: assert property (@(posedge clk) disable iff (!rst_n)
        !(mul_start && div_start));

endmodule

`default_nettype wire

// File: src/shift_add_mul.sv
`timescale 1ns/1ns
`default_nettype none

module shift_add_mul import alu_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  flush,
    input  logic  start,
    input  word_t a,
    input  word_t b,
    output logic  done,
    output word_t prod
);

    logic                 busy;
    logic [MUL_CNT_W-1:0] cnt;

    // multiplicand moves left, multiplier moves right
    word_t mcand;
    word_t mplier;
    word_t acc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else if (flush) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (cnt == MUL_LAST) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mcand  <= a;
            mplier <= b;
            acc    <= '0;
        end else if (busy) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            // bits above XLEN fall off, low product only
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign prod = acc;

    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> !busy);

endmodule

`default_nettype wire

// File: src/radix2_div.sv
`timescale 1ns/1ns
`default_nettype none

module radix2_div import alu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      flush,
    input  logic      start,
    input  div_kind_e kind,
    input  word_t     a,
    input  word_t     b,
    output logic      done,
    output word_t     res
);

    div_state_e           state;
    logic [DIV_CNT_W-1:0] cnt;

    logic      signed_op;
    logic      a_neg;
    logic      b_neg;
    word_t     mag_a;
    word_t     mag_b;
    logic      div_zero;
    logic      overflow;

    word_t     quo;
    word_t     rem;
    word_t     divisor;
    logic      q_neg;
    logic      r_neg;
    logic      is_rem;

    logic [XLEN+1:0] diff;
    word_t           q_final;
    word_t           r_final;

    assign signed_op = (kind == DK_DIV) || (kind == DK_REM);
    assign a_neg     = signed_op && a[XLEN-1];
    assign b_neg     = signed_op && b[XLEN-1];
    assign mag_a     = a_neg ? -a : a;
    assign mag_b     = b_neg ? -b : b;
    assign div_zero  = (b == '0);
    // most negative value over minus one
    assign overflow  = signed_op && (a == {1'b1, {(XLEN-1){1'b0}}}) && (b == '1);

    // trial subtract of the shifted partial remainder
    assign diff = {1'b0, rem, quo[XLEN-1]} - {2'b0, divisor};

    assign q_final = q_neg ? -quo : quo;
    // remainder takes the sign of the dividend
    assign r_final = r_neg ? -rem : rem;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= DV_IDLE;
            cnt   <= '0;
            done  <= 1'b0;
        end else if (flush) begin
            state <= DV_IDLE;
            cnt   <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                DV_IDLE: begin
                    if (start) begin
                        cnt <= '0;
                        if (div_zero || overflow) begin
                            done <= 1'b1;
                        end else begin
                            state <= DV_RUN;
                        end
                    end
                end
                DV_RUN: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == DIV_LAST) begin
                        state <= DV_FIN;
                    end
                end
                DV_FIN: begin
                    done  <= 1'b1;
                    state <= DV_IDLE;
                end
                default: state <= DV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == DV_IDLE && start) begin
            quo     <= mag_a;
            rem     <= '0;
            divisor <= mag_b;
            q_neg   <= a_neg ^ b_neg;
            r_neg   <= a_neg;
            is_rem  <= (kind == DK_REM) || (kind == DK_REMU);
            // special cases answered straight away
            if (div_zero) begin
                res <= ((kind == DK_REM) || (kind == DK_REMU)) ? a : '1;
            end else if (overflow) begin
                res <= (kind == DK_REM) ? '0 : a;
            end
        end else if (state == DV_RUN) begin
            if (!diff[XLEN+1]) begin
                rem <= diff[XLEN-1:0];
                quo <= {quo[XLEN-2:0], 1'b1};
            end else begin
                rem <= {rem[XLEN-2:0], quo[XLEN-1]};
                quo <= {quo[XLEN-2:0], 1'b0};
            end
        end else if (state == DV_FIN) begin
            res <= is_rem ? r_final : q_final;
        end
    end

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done);

endmodule

`default_nettype wire

// File: src/alu_top.sv
`timescale 1ns/1ns
`default_nettype none

module alu_top import alu_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    flush,
    input  logic    in_valid,
    output logic    in_ready,
    input  alu_op_e op,
    input  sel_a_e  sel_a,
    input  sel_b_e  sel_b,
    input  logic    word_mode,
    input  word_t   pc,
    input  word_t   rs1,
    input  word_t   rs2,
    input  word_t   csr,
    input  word_t   imm,
    output logic    out_valid,
    input  logic    out_ready,
    output word_t   res
);

    // multiplier link
    logic      mul_start;
    word_t     mul_a;
    word_t     mul_b;
    logic      mul_done;
    word_t     mul_prod;

    // divider link
    logic      div_start;
    div_kind_e div_kind;
    word_t     div_a;
    word_t     div_b;
    logic      div_done;
    word_t     div_res;

    exec_alu u_exec (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .op        (op),
        .sel_a     (sel_a),
        .sel_b     (sel_b),
        .word_mode (word_mode),
        .pc        (pc),
        .rs1       (rs1),
        .rs2       (rs2),
        .csr       (csr),
        .imm       (imm),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .res       (res),
        .mul_start (mul_start),
        .mul_a     (mul_a),
        .mul_b     (mul_b),
        .mul_done  (mul_done),
        .mul_prod  (mul_prod),
        .div_start (div_start),
        .div_kind  (div_kind),
        .div_a     (div_a),
        .div_b     (div_b),
        .div_done  (div_done),
        .div_res   (div_res)
    );

    shift_add_mul u_mul (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (flush),
        .start (mul_start),
        .a     (mul_a),
        .b     (mul_b),
        .done  (mul_done),
        .prod  (mul_prod)
    );

    radix2_div u_div (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (flush),
        .start (div_start),
        .kind  (div_kind),
        .a     (div_a),
        .b     (div_b),
        .done  (div_done),
        .res   (div_res)
    );

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // release just after an edge, away from the sampling point
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: verif/tb_alu.sv
`timescale 1ns/1ns
`default_nettype none

module tb_alu import alu_pkg::*; ();

    localparam string PAT_FILE     = "verif/alu_patterns.txt";
    localparam int    FLUSH_DELAY  = 5;
    localparam int    QUIET_CYCLES = DIV_STEPS + 10;

    logic    clk;
    logic    rst_n;
    logic    flush;
    logic    in_valid;
    logic    in_ready;
    alu_op_e op;
    sel_a_e  sel_a;
    sel_b_e  sel_b;
    logic    word_mode;
    word_t   pc;
    word_t   rs1;
    word_t   rs2;
    word_t   csr;
    word_t   imm;
    logic    out_valid;
    logic    out_ready;
    word_t   res;

    // pattern table with one entry per operation
    string   pat_name[$];
    alu_op_e pat_op[$];
    sel_a_e  pat_sel_a[$];
    sel_b_e  pat_sel_b[$];
    logic    pat_wm[$];
    word_t   pat_pc[$];
    word_t   pat_rs1[$];
    word_t   pat_rs2[$];
    word_t   pat_csr[$];
    word_t   pat_imm[$];
    word_t   pat_exp[$];
    bit      pat_flush[$];

    // expected results in issue order
    string   exp_name_q[$];
    word_t   exp_val_q[$];

    int      error_count;
    int      check_count;
    int      timeout_cycles;

    tb_clock_gen clk_gen0 (
        .clk   (clk),
        .rst_n (rst_n)
    );

    alu_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .op        (op),
        .sel_a     (sel_a),
        .sel_b     (sel_b),
        .word_mode (word_mode),
        .pc        (pc),
        .rs1       (rs1),
        .rs2       (rs2),
        .csr       (csr),
        .imm       (imm),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .res       (res)
    );

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic load_patterns();
        int    fd;
        int    n;
        int    op_val;
        bit    flush_pending;
        string line;
        string name;
        string op_str;
        word_t v_sa;
        word_t v_sb;
        word_t v_wm;
        word_t v_pc;
        word_t v_rs1;
        word_t v_rs2;
        word_t v_csr;
        word_t v_imm;
        word_t v_exp;
        flush_pending = 1'b0;
        fd = $fopen(PAT_FILE, "r");
        if (fd == 0) begin
            $display("could not open pattern file %s", PAT_FILE);
            error_count++;
            return;
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) == 0) begin
                break;
            end
            if (line.len() == 0 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %s", name, op_str);
            if (n < 2) begin
                continue;
            end
            // a marker line applies to the next operation
            if (op_str == "FLUSH") begin
                flush_pending = 1'b1;
                continue;
            end
            n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h", name, op_val, v_sa,
                        v_sb, v_wm, v_pc, v_rs1, v_rs2, v_csr, v_imm, v_exp);
            if (n != 11) begin
                $display("malformed pattern line for %s, %0d fields read", name, n);
                error_count++;
                continue;
            end
            pat_name.push_back(name);
            pat_op.push_back(alu_op_e'(op_val[4:0]));
            pat_sel_a.push_back(sel_a_e'(v_sa[0]));
            pat_sel_b.push_back(sel_b_e'(v_sb[1:0]));
            pat_wm.push_back(v_wm[0]);
            pat_pc.push_back(v_pc);
            pat_rs1.push_back(v_rs1);
            pat_rs2.push_back(v_rs2);
            pat_csr.push_back(v_csr);
            pat_imm.push_back(v_imm);
            pat_exp.push_back(v_exp);
            pat_flush.push_back(flush_pending);
            flush_pending = 1'b0;
        end
        $fclose(fd);
    endtask

    task automatic check_res(input string name, input word_t expected, input word_t actual);
        check_count++;
        if (actual !== expected) begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_no_result(input string name);
        bit seen;
        seen = 1'b0;
        check_count++;
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            if (out_valid && !seen) begin
                $display("%s: a result came out after the operation was flushed", name);
                error_count++;
                seen = 1'b1;
            end
        end
    endtask

    // holds in_valid high until the DUT takes the operation
    task automatic issue_op(input int idx);
        op        = pat_op[idx];
        sel_a     = pat_sel_a[idx];
        sel_b     = pat_sel_b[idx];
        word_mode = pat_wm[idx];
        pc        = pat_pc[idx];
        rs1       = pat_rs1[idx];
        rs2       = pat_rs2[idx];
        csr       = pat_csr[idx];
        imm       = pat_imm[idx];
        in_valid  = 1'b1;
        @(negedge clk);
        while (!in_ready) begin
            @(negedge clk);
        end
        if (!pat_flush[idx]) begin
            exp_name_q.push_back(pat_name[idx]);
            exp_val_q.push_back(pat_exp[idx]);
        end
        next_cycle();
    endtask

    task automatic wait_drained();
        @(negedge clk);
        while (exp_val_q.size() != 0 || out_valid) begin
            @(negedge clk);
        end
    endtask

    task automatic run_flushed(input int idx);
        wait_drained();
        next_cycle();
        issue_op(idx);
        in_valid = 1'b0;
        repeat (FLUSH_DELAY) next_cycle();
        flush = 1'b1;
        next_cycle();
        flush = 1'b0;
        check_no_result(pat_name[idx]);
        next_cycle();
    endtask

    initial begin
        flush       = 1'b0;
        in_valid    = 1'b0;
        op          = OP_ADD;
        sel_a       = SEL_A_RS1;
        sel_b       = SEL_B_RS2;
        word_mode   = 1'b0;
        pc          = '0;
        rs1         = '0;
        rs2         = '0;
        csr         = '0;
        imm         = '0;
        error_count = 0;
        check_count = 0;
        load_patterns();
        timeout_cycles = pat_name.size() * (DIV_STEPS + 20) + 50;
        wait (rst_n === 1'b1);
        next_cycle();
        foreach (pat_name[i]) begin
            if (pat_flush[i]) begin
                in_valid = 1'b0;
                run_flushed(i);
            end else begin
                issue_op(i);
            end
        end
        in_valid = 1'b0;
        wait_drained();
        if (check_count == 0) begin
            $display("no results were checked");
            error_count++;
        end
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // random back-pressure on the result side before each result
    initial begin
        int stall;
        void'($urandom(32'hbebf));
        out_ready = 1'b1;
        forever begin
            next_cycle();
            if (exp_val_q.size() != 0) begin
                stall = $urandom % 8;
                if (stall != 0) begin
                    out_ready = 1'b0;
                    repeat (stall) next_cycle();
                    out_ready = 1'b1;
                end
                @(negedge clk);
                while (!out_valid) begin
                    @(negedge clk);
                end
                check_res(exp_name_q[0], exp_val_q[0], res);
                void'(exp_name_q.pop_front());
                void'(exp_val_q.pop_front());
            end else if (out_valid) begin
                $display("a result came out with no operation outstanding");
                error_count++;
            end
        end
    end

    initial begin
        #1;
        repeat (timeout_cycles) @(posedge clk);
        $display("watchdog expired after %0d clock cycles, run did not complete",
                 timeout_cycles);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
src/alu_pkg.sv
src/exec_alu.sv
src/shift_add_mul.sv
src/radix2_div.sv
src/alu_top.sv
verif/tb_clock_gen.sv
verif/tb_alu.sv

// File: verif/alu_patterns.txt
# name op sel_a sel_b word_mode pc rs1 rs2 csr imm expected, all values in hex
# op FLUSH on its own marks the next operation to be flushed while in flight
add_rs1_rs2  00 1 1 0 1000 1234 111 0 0 1345
sub_pc_imm   01 0 0 0 2000 0 0 0 10 1ff0
pass_a_pc    02 0 1 0 80000000 5 6 0 0 80000000
pass_b_csr   03 1 2 0 0 5 6 deadbeef 7 deadbeef
xor_csr      04 1 2 0 0 ff00ff00ff00ff00 0 0f0f0f0f0f0f0f0f 0 f00ff00ff00ff00f
or_imm       05 1 0 0 0 a0 0 0 a aa
and_pc_rs2   06 0 1 0 12345678ffff0000 0 ffffffff00ff00ff 0 0 1234567800ff0000
sll_masked   07 1 0 0 0 1 0 0 43 8
srl_top      08 1 1 0 0 8000000000000000 3f 0 0 1
sra_neg      09 1 1 0 0 8000000000000000 4 0 0 f800000000000000
slt_neg      0a 1 1 0 0 ffffffffffffffff 1 0 0 1
sltu_big     0b 1 1 0 0 ffffffffffffffff 1 0 0 0
eq_pc_csr    0c 0 2 0 400 0 0 400 0 1
ge_signed    0d 1 0 0 0 5 0 0 fffffffffffffffb 1
geu_unsigned 0e 1 0 0 0 5 0 0 fffffffffffffffb 0
word_add     00 1 1 1 0 ffffffff00000010 1 0 0 11
word_sra     09 1 0 1 0 1234567880000000 0 0 4 f8000000
mul_small    0f 1 1 0 0 3 7 0 0 15
mul_neg      0f 1 1 0 0 ffffffffffffffff ffffffffffffffff 0 0 1
mul_wrap     0f 1 1 0 0 100000000 100000001 0 0 100000000
div_signed   10 1 1 0 0 ffffffffffffffec 6 0 0 fffffffffffffffd
rem_signed   12 1 1 0 0 ffffffffffffffec 6 0 0 fffffffffffffffe
divu_plain   11 1 1 0 0 64 7 0 0 e
remu_plain   13 1 1 0 0 64 7 0 0 2
div_zero     10 1 1 0 0 1234 0 0 0 ffffffffffffffff
rem_zero     12 1 1 0 0 1234 0 0 0 1234
divu_zero    11 1 1 0 0 1234 0 0 0 ffffffffffffffff
div_ovf      10 1 1 0 0 8000000000000000 ffffffffffffffff 0 0 8000000000000000
rem_ovf      12 1 1 0 0 8000000000000000 ffffffffffffffff 0 0 0
flush_div    FLUSH
div_flushed  11 1 1 0 0 64 7 0 0 0
after_flush  00 1 1 0 0 1 2 0 0 3
